//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // datapath width of the core
    localparam int XLEN = 64;

    // base ISA instruction width, no compressed support
    localparam int ILEN = 32;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // why the pc left its sequential path this cycle
    //   NONE   - sequential fetch
    //   BRANCH - jal or taken conditional branch, pc relative
    //   JALR   - register indirect jump
    //   TRAP   - exception or interrupt entry through mtvec
    typedef enum logic [1:0] {
        NONE   = 2'b00,
        BRANCH = 2'b01,
        JALR   = 2'b10,
        TRAP   = 2'b11
    } redirect_e;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

    // bus widths of the instruction port
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;

    // read response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // arprot bits are {instruction, non-secure, privileged}
    // fetch marks every request as an instruction access
    localparam logic [2:0] PROT_INSN = 3'b100;

endpackage

`default_nettype wire

//--- axi_lite_if.sv
`default_nettype none

// read half of AXI4-Lite, fetch never writes
interface axi_lite_if;

    // read address channel
    logic                      arvalid;
    logic                      arready;
    logic [axi_pkg::ADDR_W-1:0] araddr;
    logic [2:0]                arprot;

    // read data channel
    logic                      rvalid;
    logic                      rready;
    logic [axi_pkg::DATA_W-1:0] rdata;
    logic [1:0]                rresp;

    modport master (
        output arvalid, araddr, arprot, rready,
        input  arready, rvalid, rdata, rresp
    );

    modport slave (
        input  arvalid, araddr, arprot, rready,
        output arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

//--- if_next_pc.sv
`default_nettype none

module if_next_pc #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_ADDR = fetch_pkg::RESET_PC
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n_i,
    input  wire logic                      jal_i,
    input  wire logic                      jalr_i,
    input  wire logic                      branch_i,
    input  wire logic [fetch_pkg::XLEN-1:0] alu_res_i,
    input  wire logic [fetch_pkg::XLEN-1:0] ex_pc_i,
    input  wire logic [fetch_pkg::XLEN-1:0] ex_imm_i,
    input  wire logic [fetch_pkg::XLEN-1:0] rs1_i,
    input  wire logic                      trap_i,
    input  wire logic [fetch_pkg::XLEN-1:0] mtvec_i,
    input  wire logic                      fetch_done_i,
    input  wire logic                      halt_i,
    output logic [fetch_pkg::XLEN-1:0]      pc_o,
    output logic                           redirect_o,
    output fetch_pkg::redirect_e           redirect_cause_o
);

    logic                       taken;
    logic [fetch_pkg::XLEN-1:0] br_target;
    logic [fetch_pkg::XLEN-1:0] jalr_sum;
    logic [fetch_pkg::XLEN-1:0] jalr_target;
    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic                       jalr_tgt_q;
    fetch_pkg::redirect_e       cause;

    // branch compare result is zero when the condition holds
    assign taken       = jal_i || (branch_i && (alu_res_i == '0));
    assign br_target   = ex_pc_i + ex_imm_i;
    assign jalr_sum    = rs1_i + ex_imm_i;
    assign jalr_target = {jalr_sum[fetch_pkg::XLEN-1:1], 1'b0};

    // trap beats jal/branch, which beats jalr
    always_comb begin
        if (trap_i) begin
            cause = fetch_pkg::TRAP;
        end else if (taken) begin
            cause = fetch_pkg::BRANCH;
        end else if (jalr_i) begin
            cause = fetch_pkg::JALR;
        end else begin
            cause = fetch_pkg::NONE;
        end
    end

    assign redirect_o       = (cause != fetch_pkg::NONE);
    assign redirect_cause_o = cause;
    assign pc_o             = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_ADDR;
            jalr_tgt_q <= 1'b0;
        end else begin
            case (cause)
                fetch_pkg::TRAP: begin
                    pc_q       <= mtvec_i;
                    jalr_tgt_q <= 1'b0;
                end
                fetch_pkg::BRANCH: begin
                    pc_q       <= br_target;
                    jalr_tgt_q <= 1'b0;
                end
                fetch_pkg::JALR: begin
                    pc_q       <= jalr_target;
                    jalr_tgt_q <= 1'b1;
                end
                default: begin
                    // sequential step once the current word is in the queue
                    if (fetch_done_i && !halt_i) begin
                        pc_q <= pc_q + fetch_pkg::XLEN'(fetch_pkg::ILEN / 8);
                    end
                end
            endcase
        end
    end

    // only a jalr can leave the pc off a word boundary
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (pc_q[1:0] != 2'b00) |-> (jalr_tgt_q && !pc_q[0]))
        else $error("pc misaligned without a jalr target: %h", pc_q);

    cover property (@(posedge clk) disable iff (!rst_n_i) jalr_tgt_q && pc_q[1]);

endmodule

`default_nettype wire

//--- if_axi_reader.sv
`default_nettype none

module if_axi_reader #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n_i,
    input  wire logic [fetch_pkg::XLEN-1:0]          pc_i,
    input  wire logic                               redirect_i,
    input  wire logic [$clog2(QUEUE_DEPTH):0]        free_slots_i,
    axi_lite_if.master                              axi,
    output logic                                    fetch_done_o,
    output logic                                    halt_o,
    output logic                                    push_o,
    output logic [fetch_pkg::ILEN-1:0]               push_inst_o,
    output logic [fetch_pkg::XLEN-1:0]               push_pc_o,
    output logic                                    push_err_o
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        DATA = 2'b10
    } state_e;

    state_e                     state_q;
    logic [axi_pkg::ADDR_W-1:0] araddr_q;
    logic [fetch_pkg::XLEN-1:0] req_pc_q;
    logic                       stale_q;
    logic                       halt_q;
    logic                       rd_open_q;
    logic                       issue;
    logic                       beat_acc;
    logic                       beat_keep;
    logic                       beat_ok;

    // one read at a time, and only with room to push its result
    assign issue = (state_q == IDLE) && !redirect_i && !halt_q && (free_slots_i != '0);

    // beats are always accepted, stale or not
    assign beat_acc  = (state_q == DATA) && axi.rvalid && axi.rready;
    assign beat_keep = beat_acc && !stale_q && !redirect_i;
    assign beat_ok   = (axi.rresp == axi_pkg::RESP_OKAY);

    assign axi.arvalid = (state_q == ADDR);
    assign axi.araddr  = araddr_q;
    assign axi.arprot  = axi_pkg::PROT_INSN;
    assign axi.rready  = 1'b1;

    // upper or lower word of the beat by pc bit 2
    assign push_inst_o  = req_pc_q[2] ? axi.rdata[63:32] : axi.rdata[31:0];
    assign push_pc_o    = req_pc_q;
    assign push_err_o   = !beat_ok;
    assign push_o       = beat_keep;
    assign fetch_done_o = beat_keep && beat_ok;
    assign halt_o       = halt_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (issue) begin
                        state_q <= ADDR;
                    end
                end
                ADDR: begin
                    if (axi.arready) begin
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (beat_acc) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request address and pc are captured at issue and held
    always_ff @(posedge clk) begin
        if (issue) begin
            araddr_q <= {pc_i[axi_pkg::ADDR_W-1:3], 3'b000};
            req_pc_q <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stale_q <= 1'b0;
            halt_q  <= 1'b0;
        end else begin
            // a redirect during a read makes its beat worthless
            if (beat_acc) begin
                stale_q <= 1'b0;
            end else if (redirect_i && (state_q != IDLE)) begin
                stale_q <= 1'b1;
            end

            // error stops fetch until the pc is redirected
            if (redirect_i) begin
                halt_q <= 1'b0;
            end else if (beat_keep && !beat_ok) begin
                halt_q <= 1'b1;
            end
        end
    end

    // bus level view of an open read
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_open_q <= 1'b0;
        end else if (axi.arvalid && axi.arready) begin
            rd_open_q <= 1'b1;
        end else if (axi.rvalid && axi.rready) begin
            rd_open_q <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (axi.arvalid && !axi.arready) |=> (axi.arvalid && $stable(axi.araddr)))
        else $error("araddr changed while AR was pending");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        axi.arvalid |-> !rd_open_q)
        else $error("AR issued with a read outstanding");

endmodule

`default_nettype wire

//--- if_inst_queue.sv
`default_nettype none

module if_inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    input  wire logic                        flush_i,
    input  wire logic                        push_i,
    input  wire logic [fetch_pkg::ILEN-1:0]   push_inst_i,
    input  wire logic [fetch_pkg::XLEN-1:0]   push_pc_i,
    input  wire logic                        push_err_i,
    input  wire logic                        inst_ready_i,
    output logic [$clog2(QUEUE_DEPTH):0]      free_slots_o,
    output logic                             inst_valid_o,
    output logic [fetch_pkg::ILEN-1:0]        inst_o,
    output logic [fetch_pkg::XLEN-1:0]        inst_pc_o,
    output logic                             fetch_err_o
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    logic [fetch_pkg::ILEN-1:0] inst_mem [QUEUE_DEPTH];
    logic [fetch_pkg::XLEN-1:0] pc_mem   [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0]     err_mem;
    logic [AW-1:0]              wr_ptr_q;
    logic [AW-1:0]              rd_ptr_q;
    logic [AW:0]                count_q;
    logic                       pop;

    assign inst_valid_o = (count_q != '0);
    assign pop          = inst_valid_o && inst_ready_i;
    assign free_slots_o = (AW + 1)'(QUEUE_DEPTH) - count_q;

    // head entry straight out of storage
    assign inst_o      = inst_mem[rd_ptr_q];
    assign inst_pc_o   = pc_mem[rd_ptr_q];
    assign fetch_err_o = inst_valid_o && err_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !flush_i) begin
            inst_mem[wr_ptr_q] <= push_inst_i;
            pc_mem[wr_ptr_q]   <= push_pc_i;
            err_mem[wr_ptr_q]  <= push_err_i;
        end
    end

    // reader credit check must keep us from overrunning
    assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> (free_slots_o != '0))
        else $error("push into a full instruction queue");

endmodule

`default_nettype wire

//--- if_stage_top.sv
`default_nettype none

module if_stage_top #(
    parameter int                         QUEUE_DEPTH = 4,
    parameter logic [fetch_pkg::XLEN-1:0] RESET_ADDR  = fetch_pkg::RESET_PC
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n_i,
    // redirect sources from execute/memory
    input  wire logic                        jal_i,
    input  wire logic                        jalr_i,
    input  wire logic                        branch_i,
    input  wire logic [fetch_pkg::XLEN-1:0]   alu_res_i,
    input  wire logic [fetch_pkg::XLEN-1:0]   ex_pc_i,
    input  wire logic [fetch_pkg::XLEN-1:0]   ex_imm_i,
    input  wire logic [fetch_pkg::XLEN-1:0]   rs1_i,
    input  wire logic                        trap_i,
    input  wire logic [fetch_pkg::XLEN-1:0]   mtvec_i,
    // AXI4-Lite read master
    output logic                             m_axi_arvalid_o,
    input  wire logic                        m_axi_arready_i,
    output logic [axi_pkg::ADDR_W-1:0]        m_axi_araddr_o,
    output logic [2:0]                       m_axi_arprot_o,
    input  wire logic                        m_axi_rvalid_i,
    output logic                             m_axi_rready_o,
    input  wire logic [axi_pkg::DATA_W-1:0]   m_axi_rdata_i,
    input  wire logic [1:0]                  m_axi_rresp_i,
    // to decode
    output logic                             inst_valid_o,
    input  wire logic                        inst_ready_i,
    output logic [fetch_pkg::ILEN-1:0]        inst_o,
    output logic [fetch_pkg::XLEN-1:0]        inst_pc_o,
    output logic                             fetch_err_o
);

    logic [fetch_pkg::XLEN-1:0]     pc;
    logic                           redirect;
    fetch_pkg::redirect_e           redirect_cause;
    logic                           queue_flush;
    logic                           fetch_done;
    logic                           halt;
    logic                           push;
    logic [fetch_pkg::ILEN-1:0]     push_inst;
    logic [fetch_pkg::XLEN-1:0]     push_pc;
    logic                           push_err;
    logic [$clog2(QUEUE_DEPTH):0]   free_slots;

    axi_lite_if axi_bus ();

    assign m_axi_arvalid_o = axi_bus.arvalid;
    assign m_axi_araddr_o  = axi_bus.araddr;
    assign m_axi_arprot_o  = axi_bus.arprot;
    assign m_axi_rready_o  = axi_bus.rready;
    assign axi_bus.arready = m_axi_arready_i;
    assign axi_bus.rvalid  = m_axi_rvalid_i;
    assign axi_bus.rdata   = m_axi_rdata_i;
    assign axi_bus.rresp   = m_axi_rresp_i;

    // any redirect cause empties the queue
    assign queue_flush = (redirect_cause != fetch_pkg::NONE);

    if_next_pc #(
        .RESET_ADDR (RESET_ADDR)
    ) u_next_pc (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .jal_i            (jal_i),
        .jalr_i           (jalr_i),
        .branch_i         (branch_i),
        .alu_res_i        (alu_res_i),
        .ex_pc_i          (ex_pc_i),
        .ex_imm_i         (ex_imm_i),
        .rs1_i            (rs1_i),
        .trap_i           (trap_i),
        .mtvec_i          (mtvec_i),
        .fetch_done_i     (fetch_done),
        .halt_i           (halt),
        .pc_o             (pc),
        .redirect_o       (redirect),
        .redirect_cause_o (redirect_cause)
    );

    if_axi_reader #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_axi_reader (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc),
        .redirect_i   (redirect),
        .free_slots_i (free_slots),
        .axi          (axi_bus),
        .fetch_done_o (fetch_done),
        .halt_o       (halt),
        .push_o       (push),
        .push_inst_o  (push_inst),
        .push_pc_o    (push_pc),
        .push_err_o   (push_err)
    );

    if_inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (queue_flush),
        .push_i       (push),
        .push_inst_i  (push_inst),
        .push_pc_i    (push_pc),
        .push_err_i   (push_err),
        .inst_ready_i (inst_ready_i),
        .free_slots_o (free_slots),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .fetch_err_o  (fetch_err_o)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`default_nettype none

// AXI4-Lite read slave standing in for instruction memory
module tb_mem_model #(
    parameter int MAX_DELAY = 5
) (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire logic        arvalid_i,
    input  wire logic [63:0] araddr_i,
    input  wire logic        rready_i,
    input  wire logic [63:0] err_lo_i,
    input  wire logic [63:0] err_hi_i,
    output logic             arready_o,
    output logic             rvalid_o,
    output logic [63:0]      rdata_o,
    output logic [1:0]       rresp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] WORD_KEY = 32'h1357_9BDF;

    logic [63:0] beat_addr;
    logic        in_window;
    logic        counting;
    int unsigned wait_left;

    // every word is its own address scrambled with a fixed key
    function automatic logic [31:0] word_at(input logic [63:0] addr);
        return addr[31:0] ^ WORD_KEY;
    endfunction

    assign beat_addr = {araddr_i[63:3], 3'b000};
    // error window is half open [lo, hi)
    assign in_window = (beat_addr >= err_lo_i) && (beat_addr < err_hi_i);

    initial begin
        arready_o <= 1'b0;
        rvalid_o  <= 1'b0;
        rdata_o   <= '0;
        rresp_o   <= axi_pkg::RESP_OKAY;
        counting  <= 1'b0;
        wait_left <= 0;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= axi_pkg::RESP_OKAY;
            counting  <= 1'b0;
            wait_left <= 0;
        end else if (arvalid_i && arready_o) begin
            // address taken and data follows on the next cycle
            arready_o <= 1'b0;
            rvalid_o  <= 1'b1;
            if (in_window) begin
                rdata_o <= '0;
                rresp_o <= axi_pkg::RESP_SLVERR;
            end else begin
                rdata_o <= {word_at(beat_addr + 64'd4), word_at(beat_addr)};
                rresp_o <= axi_pkg::RESP_OKAY;
            end
        end else if (rvalid_o) begin
            if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end else if (arvalid_i && !counting && !arready_o) begin
            counting  <= 1'b1;
            wait_left <= $urandom_range(MAX_DELAY, 0);
        end else if (counting) begin
            if (wait_left == 0) begin
                counting  <= 1'b0;
                arready_o <= 1'b1;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_if_stage.sv
`default_nettype none

module tb_if_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          QUEUE_DEPTH    = 4;
    localparam int          SEED           = 83;
    // all five tests together need a few thousand cycles at most
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [63:0] BOOT_PC        = 64'h0000_0000_8000_0000;
    localparam logic [31:0] WORD_KEY       = 32'h1357_9BDF;

    logic        clk;
    logic        rst_n;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        trap;
    logic [63:0] alu_res;
    logic [63:0] ex_pc;
    logic [63:0] ex_imm;
    logic [63:0] rs1;
    logic [63:0] mtvec;
    logic        arvalid;
    logic        arready;
    logic [63:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [63:0] rdata;
    logic [1:0]  rresp;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic [63:0] inst_pc;
    logic        fetch_err;
    logic [63:0] err_lo;
    logic [63:0] err_hi;

    // what decode has accepted in arrival order
    logic [63:0] got_pc[$];
    logic [31:0] got_inst[$];
    logic        got_err[$];

    logic [63:0] exp_pc;
    string       active_test = "reset";
    int          cycles = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_done = 0;

    if_stage_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .jal_i           (jal),
        .jalr_i          (jalr),
        .branch_i        (branch),
        .alu_res_i       (alu_res),
        .ex_pc_i         (ex_pc),
        .ex_imm_i        (ex_imm),
        .rs1_i           (rs1),
        .trap_i          (trap),
        .mtvec_i         (mtvec),
        .m_axi_arvalid_o (arvalid),
        .m_axi_arready_i (arready),
        .m_axi_araddr_o  (araddr),
        .m_axi_arprot_o  (arprot),
        .m_axi_rvalid_i  (rvalid),
        .m_axi_rready_o  (rready),
        .m_axi_rdata_i   (rdata),
        .m_axi_rresp_i   (rresp),
        .inst_valid_o    (inst_valid),
        .inst_ready_i    (inst_ready),
        .inst_o          (inst),
        .inst_pc_o       (inst_pc),
        .fetch_err_o     (fetch_err)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .arvalid_i (arvalid),
        .araddr_i  (araddr),
        .rready_i  (rready),
        .err_lo_i  (err_lo),
        .err_hi_i  (err_hi),
        .arready_o (arready),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata),
        .rresp_o   (rresp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, fetch stopped delivering instructions", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // decode handshake monitor
    always @(posedge clk) begin
        if (rst_n && inst_valid && inst_ready) begin
            got_pc.push_back(inst_pc);
            got_inst.push_back(inst);
            got_err.push_back(fetch_err);
        end
    end

    // every fetch request carries the instruction bit of arprot
    always @(posedge clk) begin
        if (rst_n && arvalid) begin
            assert (arprot[2]) else begin
                $display("Mismatch %s: arprot[2] expected 1 actual %b", active_test, arprot[2]);
                test_errors++;
            end
        end
    end

    function automatic logic [31:0] rule_word(input logic [63:0] addr);
        return addr[31:0] ^ WORD_KEY;
    endfunction

    // pops count entries and expects a clean sequential run from exp_pc
    task automatic check_stream(input string name, input int count);
        logic [63:0] pc_act;
        logic [31:0] inst_act;
        logic        err_act;
        for (int i = 0; i < count; i++) begin
            while (got_pc.size() == 0) @(posedge clk);
            pc_act   = got_pc.pop_front();
            inst_act = got_inst.pop_front();
            err_act  = got_err.pop_front();
            checks   = checks + 1;
            assert (pc_act == exp_pc) else begin
                $display("Mismatch %s: pc expected %h actual %h", name, exp_pc, pc_act);
                test_errors++;
            end
            assert (inst_act == rule_word(exp_pc)) else begin
                $display("Mismatch %s: inst expected %h actual %h",
                         name, rule_word(exp_pc), inst_act);
                test_errors++;
            end
            assert (!err_act) else begin
                $display("%s: fetch error reported at pc %h on a good address", name, pc_act);
                test_errors++;
            end
            exp_pc = exp_pc + 64'd4;
        end
    endtask

    // one cycle of redirect inputs with decode held off on the sampling edge
    task automatic pulse_redirect(input logic do_jal, input logic do_jalr,
                                  input logic do_branch, input logic do_trap,
                                  input logic [63:0] alu_v, input logic [63:0] pc_v,
                                  input logic [63:0] imm_v, input logic [63:0] rs1_v,
                                  input logic [63:0] mtvec_v);
        logic        taken;
        logic [63:0] target;
        taken  = 1'b1;
        target = exp_pc;
        // trap first, then jal or taken branch, then jalr
        if (do_trap) begin
            target = mtvec_v;
        end else if (do_jal || (do_branch && (alu_v == 64'd0))) begin
            target = pc_v + imm_v;
        end else if (do_jalr) begin
            target = (rs1_v + imm_v) & ~64'd1;
        end else begin
            taken = 1'b0;
        end
        @(posedge clk);
        inst_ready <= 1'b0;
        jal        <= do_jal;
        jalr       <= do_jalr;
        branch     <= do_branch;
        trap       <= do_trap;
        alu_res    <= alu_v;
        ex_pc      <= pc_v;
        ex_imm     <= imm_v;
        rs1        <= rs1_v;
        mtvec      <= mtvec_v;
        @(posedge clk);
        jal        <= 1'b0;
        jalr       <= 1'b0;
        branch     <= 1'b0;
        trap       <= 1'b0;
        inst_ready <= 1'b1;
        if (taken) begin
            got_pc.delete();
            got_inst.delete();
            got_err.delete();
            exp_pc = target;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        total_errors = total_errors + test_errors;
        test_errors  = 0;
        tests_done   = tests_done + 1;
    endtask

    task automatic fetch_sequential();
        active_test = "sequential";
        // outputs right after the last reset edge
        @(negedge clk);
        checks = checks + 1;
        assert ({arvalid, inst_valid, fetch_err, rready} == 4'b0001) else begin
            $display("Mismatch sequential: arvalid/inst_valid/fetch_err/rready %s %b %s %b",
                     "after reset expected", 4'b0001,
                     "actual", {arvalid, inst_valid, fetch_err, rready});
            test_errors++;
        end
        check_stream("sequential", 32);
        finish_test("sequential");
    endtask

    task automatic redirect_targets();
        active_test = "redirects";
        pulse_redirect(1'b1, 1'b0, 1'b0, 1'b0, 64'd0, 64'h8000_0100, 64'h400, 64'd0, 64'd0);
        check_stream("redirects", 6);
        // taken branch with a negative offset
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 64'd0, 64'h8000_0510,
                       64'hFFFF_FFFF_FFFF_FF00, 64'd0, 64'd0);
        check_stream("redirects", 6);
        pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 64'd1, 64'h8000_0900, 64'h100, 64'd0, 64'd0);
        check_stream("redirects", 6);
        // odd sum drops bit 0
        pulse_redirect(1'b0, 1'b1, 1'b0, 1'b0, 64'd0, 64'd0, 64'h20, 64'h8000_2001, 64'd0);
        check_stream("redirects", 6);
        finish_test("redirects");
    endtask

    task automatic trap_over_jal();
        active_test = "trap_priority";
        pulse_redirect(1'b1, 1'b0, 1'b0, 1'b1, 64'd0, 64'h8000_0000, 64'h800, 64'd0,
                       64'h8000_3000);
        check_stream("trap_priority", 6);
        finish_test("trap_priority");
    endtask

    task automatic backpressure_hold();
        active_test = "backpressure";
        @(posedge clk);
        inst_ready <= 1'b0;
        repeat (50) @(posedge clk);
        @(negedge clk);
        assert (inst_valid && !arvalid) else begin
            $display("backpressure: queue not holding or AR still issued while decode stalls");
            test_errors++;
        end
        @(posedge clk);
        inst_ready <= 1'b1;
        check_stream("backpressure", 24);
        finish_test("backpressure");
    endtask

    task automatic error_stop();
        logic [63:0] pc_act;
        logic        err_act;
        active_test = "error_response";
        @(posedge clk);
        err_lo <= 64'h8000_6010;
        err_hi <= 64'h8000_6018;
        pulse_redirect(1'b1, 1'b0, 1'b0, 1'b0, 64'd0, 64'h8000_5000, 64'h1000, 64'd0, 64'd0);
        check_stream("error_response", 4);
        while (got_pc.size() == 0) @(posedge clk);
        pc_act  = got_pc.pop_front();
        err_act = got_err.pop_front();
        void'(got_inst.pop_front());
        checks  = checks + 1;
        assert (pc_act == exp_pc) else begin
            $display("Mismatch error_response: pc expected %h actual %h", exp_pc, pc_act);
            test_errors++;
        end
        assert (err_act) else begin
            $display("Mismatch error_response: fetch_err expected 1 actual %0b", err_act);
            test_errors++;
        end
        // nothing more may come until the pc is redirected
        repeat (40) @(negedge clk);
        assert ((got_pc.size() == 0) && !inst_valid) else begin
            $display("error_response: fetch continued after an error response");
            test_errors++;
        end
        pulse_redirect(1'b0, 1'b0, 1'b0, 1'b1, 64'd0, 64'd0, 64'd0, 64'd0, 64'h8000_7000);
        check_stream("error_response", 8);
        finish_test("error_response");
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n      <= 1'b0;
        jal        <= 1'b0;
        jalr       <= 1'b0;
        branch     <= 1'b0;
        trap       <= 1'b0;
        alu_res    <= '0;
        ex_pc      <= '0;
        ex_imm     <= '0;
        rs1        <= '0;
        mtvec      <= '0;
        inst_ready <= 1'b1;
        err_lo     <= '0;
        err_hi     <= '0;
        exp_pc     = BOOT_PC;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        fetch_sequential();
        redirect_targets();
        trap_over_jal();
        backpressure_hold();
        error_stop();

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, total_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
fetch_pkg.sv
axi_pkg.sv
axi_lite_if.sv
if_next_pc.sv
if_axi_reader.sv
if_inst_queue.sv
if_stage_top.sv
tb_mem_model.sv
tb_if_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch stage regression with Verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_if_stage -f build.f -o tb_if_stage_sim

./obj_dir/tb_if_stage_sim | tee "$LOG"

if grep -q "Regression failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

if ! grep -q "Regression passed" "$LOG"; then
    echo "simulation ended without a result line, see $LOG"
    exit 1
fi

echo "simulation finished cleanly"
